// ==== list.f ====
rtl/icache_pkg.sv
rtl/icache_way_ram.sv
rtl/icache_replace.sv
rtl/icache_refill.sv
rtl/icache.sv
bench/icache_props.sv
bench/icache_tb.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --assert --timing -j 0
TOP      = icache_tb
FILELIST = list.f
OBJDIR   = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench, pass when the log holds the pass line"
	@echo "  clean  remove build output and log"
	@echo "  help   this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	-./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "TEST PASS" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== bench/icache_tb.sv ====
`timescale 1ns/1ps

module icache_tb;

	// 309 fetches that each take under 40 cycles with the slowest memory
	localparam int max_cycles = 20000;

	logic        clk;
	logic        rst;
	logic        cpu_req;
	logic [31:0] instr_addr;
	logic        cpu_addr_ok;
	logic        cpu_data_ok;
	logic [31:0] instr_rdata;
	logic        mem_req;
	logic [31:0] mem_read_addr;
	logic [31:0] mem_read_data;
	logic        mem_addr_ok;
	logic        mem_data_ok;

	logic [31:0] lfsr = 32'hd825;
	int          cycles = 0;
	logic [31:0] pend_q[$];  // accepted addresses with the oldest first
	int          addr_wait = 0;
	int          data_wait = 0;
	logic        refill_seen = 1'b0; // mem_req came up during the latest fetch

	icache #(.ways(2), .sets(16), .words(4)) u_icache (
		.clk(clk), .rst(rst), .cpu_req(cpu_req), .instr_addr(instr_addr),
		.cpu_addr_ok(cpu_addr_ok), .cpu_data_ok(cpu_data_ok), .instr_rdata(instr_rdata),
		.mem_req(mem_req), .mem_read_addr(mem_read_addr), .mem_read_data(mem_read_data),
		.mem_addr_ok(mem_addr_ok), .mem_data_ok(mem_data_ok)
	);

	// galois lfsr stepped once per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++)
		begin
			r = {r[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
		end
		return r;
	endfunction

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// memory model sees transfers at the falling edge and drives after the rising one
	initial
	begin
		mem_addr_ok   = 1'b0;
		mem_data_ok   = 1'b0;
		mem_read_data = '0;
		forever
		begin
			@(negedge clk);
			if (mem_data_ok)
			begin
				void'(pend_q.pop_front());
				data_wait = int'(rand_bits(2));
			end
			else if (pend_q.size() > 0 && data_wait > 0)
				data_wait--;
			if (mem_req && mem_addr_ok)
			begin
				pend_q.push_back(mem_read_addr); // data earliest in the next cycle
				addr_wait = int'(rand_bits(2));
			end
			else if (mem_req && addr_wait > 0)
				addr_wait--;
			@(posedge clk);
			#1;
			mem_addr_ok = (addr_wait == 0);
			mem_data_ok = (pend_q.size() > 0) && (data_wait == 0);
			mem_read_data = (pend_q.size() > 0) ? (pend_q[0] ^ 32'h5a5a_0000) : '0;
		end
	end

	// one fetch that holds the address until the hit
	// entered and left 1 ns after a rising edge
	task automatic fetch(input logic [31:0] a);
		cpu_req     = 1'b1;
		instr_addr  = a;
		refill_seen = 1'b0;
		forever
		begin
			@(negedge clk);
			if (mem_req)
				refill_seen = 1'b1;
			if (cpu_data_ok)
				break;
		end
		@(posedge clk);
		#1;
		cpu_req = 1'b0;
	endtask

	// whether the latest fetch went out to memory
	task automatic check_refill(input logic exp);
		assert (refill_seen == exp)
		else
		begin
			$display("ERR mem_req exp %h got %h during the fetch of %h", exp, refill_seen,
				instr_addr);
			$display("TEST FAIL");
			$fatal(1);
		end
	endtask

	always @(posedge clk)
	begin
		cycles++;
		if (cycles >= max_cycles)
		begin
			$display("timeout, the run did not finish within %0d cycles", max_cycles);
			$display("TEST FAIL");
			$fatal(1);
		end
	end

	// stop at the first failed assertion
	always @(negedge clk)
	begin
		if (u_icache.u_props.err_cnt != 0)
		begin
			$display("TEST FAIL");
			$fatal(1);
		end
	end

	initial
	begin
		rst        = 1'b1;
		cpu_req    = 1'b0;
		instr_addr = '0;
		repeat (10) @(posedge clk);
		#1;
		rst = 1'b0;
		for (int w = 0; w < 4; w++)
			fetch(32'h0000_0100 + 32'(w * 4)); // one miss and then hits on the rest of the line
		fetch(32'h0000_1010); // three tags in set 1
		fetch(32'h0000_2010);
		fetch(32'h0000_3010);
		fetch(32'h0000_1010); // evicted by the third tag
		check_refill(1'b1);
		fetch(32'h0000_3014); // third tag still resident
		check_refill(1'b0);
		for (int i = 0; i < 300; i++)
		begin
			fetch((rand_bits(3) << 12) | (rand_bits(2) << 4) | (rand_bits(2) << 2));
			if (rand_bits(1) != 0)
			begin
				@(posedge clk); // idle gap now and then
				#1;
			end
		end
		repeat (4) @(negedge clk);
		if (u_icache.u_props.err_cnt == 0)
		begin
			$display("TEST PASS");
			$finish;
		end
		else
		begin
			$display("TEST FAIL");
			$fatal(1);
		end
	end

endmodule

// ==== bench/icache_props.sv ====
`timescale 1ns/1ps

module icache_props #(
	parameter int ways  = 2,
	parameter int words = 4
)(
	input logic                   clk,
	input logic                   rst,
	input logic                   cpu_req,
	input logic [31:0]            instr_addr,
	input logic                   cpu_addr_ok,
	input logic                   cpu_data_ok,
	input logic [31:0]            instr_rdata,
	input logic                   mem_req,
	input logic [31:0]            mem_read_addr,
	input logic                   mem_addr_ok,
	input logic                   fill_we,
	input logic [$clog2(ways)-1:0] victim_way
);
	localparam int lo = $clog2(words) + 2; // lowest line address bit

	int              err_cnt = 0; // watched by the testbench top
	logic [31:0]     exp_data;
	logic [31-lo:0]  last_line;   // line written by the latest fill
	logic            last_ok;

	assign exp_data = {instr_addr[31:2], 2'b00} ^ 32'h5a5a_0000;

	always_ff @(posedge clk)
	begin
		if (rst)
			last_ok <= 1'b0;
		else if (fill_we)
		begin
			last_ok   <= 1'b1;
			last_line <= instr_addr[31:lo]; // the newest fill of any set stays resident
		end
	end

	a_data: assert property (@(posedge clk) cpu_data_ok |-> instr_rdata == exp_data)
		else
		begin
			$error("ERR instr_rdata exp %h got %h", $sampled(exp_data),
				$sampled(instr_rdata));
			err_cnt++;
		end
	a_ok_pair: assert property (@(posedge clk) cpu_addr_ok == cpu_data_ok)
		else
		begin
			$error("ERR cpu_addr_ok exp %h got %h", $sampled(cpu_data_ok),
				$sampled(cpu_addr_ok));
			err_cnt++;
		end
	a_reset: assert property (@(posedge clk)
		rst |=> !mem_req && !cpu_addr_ok && !cpu_data_ok)
		else
		begin
			$error("ERR mem_req cpu_addr_ok cpu_data_ok exp 0 0 0 got %h %h %h after reset",
				$sampled(mem_req), $sampled(cpu_addr_ok), $sampled(cpu_data_ok));
			err_cnt++;
		end
	a_line_hit: assert property (@(posedge clk) disable iff (rst)
		cpu_req && last_ok && instr_addr[31:lo] == last_line |-> cpu_data_ok && !mem_req)
		else
		begin
			$error("ERR cpu_data_ok exp 1 got %h on filled line", $sampled(cpu_data_ok));
			err_cnt++;
		end
	a_addr_line: assert property (@(posedge clk) disable iff (rst)
		mem_req |-> mem_read_addr[1:0] == 2'b00 && mem_read_addr[31:lo] == instr_addr[31:lo])
		else
		begin
			$error("ERR mem_read_addr got %h for instr_addr %h", $sampled(mem_read_addr),
				$sampled(instr_addr));
			err_cnt++;
		end
	a_addr_first: assert property (@(posedge clk) disable iff (rst)
		$rose(mem_req) |-> mem_read_addr[lo-1:2] == '0)
		else
		begin
			$error("ERR mem_read_addr offset exp 0 got %h", $sampled(mem_read_addr));
			err_cnt++;
		end
	a_addr_step: assert property (@(posedge clk) disable iff (rst)
		mem_req && mem_addr_ok |=>
			!mem_req || mem_read_addr == $past(mem_read_addr) + 32'd4)
		else
		begin
			$error("ERR mem_read_addr exp %h got %h", $past(mem_read_addr) + 32'd4,
				$sampled(mem_read_addr));
			err_cnt++;
		end
	a_hold: assert property (@(posedge clk) disable iff (rst)
		mem_req && !mem_addr_ok |=> mem_req && $stable(mem_read_addr))
		else
		begin
			$error("ERR mem_read_addr exp %h got %h under back-pressure",
				$past(mem_read_addr), $sampled(mem_read_addr));
			err_cnt++;
		end
	// round robin moves on by one way and wraps at ways
	a_victim: assert property (@(posedge clk) disable iff (rst)
		fill_we |=> int'(victim_way) == (int'($past(victim_way)) + 1) % ways)
		else
		begin
			$error("ERR victim_way exp %h got %h after a fill",
				(int'($past(victim_way)) + 1) % ways, $sampled(victim_way));
			err_cnt++;
		end

endmodule

bind icache icache_props #(.ways(ways), .words(words)) u_props (
	.clk(clk), .rst(rst), .cpu_req(cpu_req), .instr_addr(instr_addr),
	.cpu_addr_ok(cpu_addr_ok), .cpu_data_ok(cpu_data_ok), .instr_rdata(instr_rdata),
	.mem_req(mem_req), .mem_read_addr(mem_read_addr), .mem_addr_ok(mem_addr_ok),
	.fill_we(fill_we), .victim_way(victim_way)
);

// ==== rtl/icache.sv ====
`timescale 1ns/1ps

module icache #(
	parameter int ways  = icache_pkg::def_ways,
	parameter int sets  = icache_pkg::def_sets,
	parameter int words = icache_pkg::def_words
)(
	input  logic                          clk,
	input  logic                          rst,
	// cpu fetch port
	input  logic                          cpu_req,       // level, address held while high
	input  logic [icache_pkg::addr_w-1:0] instr_addr,
	output logic                          cpu_addr_ok,
	output logic                          cpu_data_ok,   // same cycle as the hit
	output logic [icache_pkg::word_w-1:0] instr_rdata,
	// memory read port
	output logic                          mem_req,
	output logic [icache_pkg::addr_w-1:0] mem_read_addr,
	input  logic [icache_pkg::word_w-1:0] mem_read_data,
	input  logic                          mem_addr_ok,
	input  logic                          mem_data_ok
);
	import icache_pkg::*;

	// address split, tag | index | word offset | byte offset
	localparam int idx_w  = $clog2(sets);
	localparam int off_w  = $clog2(words);
	localparam int tag_w  = addr_w - idx_w - off_w - 2;
	localparam int way_w  = $clog2(ways);
	localparam int line_w = words * word_w;

	logic [tag_w-1:0] lookup_tag;
	logic [idx_w-1:0] lookup_index;
	logic [off_w-1:0] lookup_off;   // word inside the line

	logic [ways-1:0]  way_valid;    // per way read of the addressed set
	logic [tag_w-1:0] way_tag  [ways];
	logic [line_w-1:0] way_line [ways];
	logic [ways-1:0]  way_we;       // fill strobe, victim way only
	logic [ways-1:0]  hit_vec;      // one hot, at most one way matches

	logic [line_w-1:0] hit_line;
	logic              hit;
	logic              miss;
	logic [way_w-1:0]  victim_way;
	logic [line_w-1:0] fill_line;
	logic              fill_we;

	assign lookup_tag   = instr_addr[addr_w-1 -: tag_w];
	assign lookup_index = instr_addr[off_w+2 +: idx_w];
	assign lookup_off   = instr_addr[2 +: off_w]; // low two bits ignored

	// one tag and data array per way
	for (genvar w = 0; w < ways; w++)
	begin : g_way
		assign way_we[w]  = fill_we && (victim_way == way_w'(w));
		assign hit_vec[w] = way_valid[w] && (way_tag[w] == lookup_tag);

		icache_way_ram #(
			.sets  (sets),
			.words (words)
		) u_way_ram (
			.clk   (clk),
			.rst   (rst),
			.index (lookup_index),
			.we    (way_we[w]),
			.wtag  (lookup_tag),   // cpu holds the address for the whole refill
			.wline (fill_line),
			.valid (way_valid[w]),
			.tag   (way_tag[w]),
			.line  (way_line[w])
		);
	end

	// and-or select of the hitting line, hit_vec is one hot
	always_comb
	begin
		hit_line = '0;
		for (int w = 0; w < ways; w++)
		begin
			if (hit_vec[w])
				hit_line |= way_line[w];
		end
	end

	assign hit  = cpu_req && (|hit_vec);
	assign miss = cpu_req && !(|hit_vec); // held until the fill lands

	// hit answers in the same cycle, address and data together
	assign cpu_addr_ok = hit;
	assign cpu_data_ok = hit;
	assign instr_rdata = hit_line[lookup_off*word_w +: word_w];

	// victim pointer per set
	icache_replace #(
		.ways (ways),
		.sets (sets)
	) u_replace (
		.clk        (clk),
		.rst        (rst),
		.index      (lookup_index),
		.fill_we    (fill_we),
		.victim_way (victim_way)
	);

	// miss handling and memory port
	icache_refill #(
		.sets  (sets),
		.words (words)
	) u_refill (
		.clk           (clk),
		.rst           (rst),
		.miss          (miss),
		.lookup_tag    (lookup_tag),
		.lookup_index  (lookup_index),
		.mem_req       (mem_req),
		.mem_read_addr (mem_read_addr),
		.mem_addr_ok   (mem_addr_ok),
		.mem_read_data (mem_read_data),
		.mem_data_ok   (mem_data_ok),
		.fill_line     (fill_line),
		.fill_we       (fill_we)
	);

	// timing summary
	// hit  - cpu_req to cpu_data_ok in the same cycle
	// miss - refill runs, fill_we writes the victim way and steps its pointer,
	//        the lookup hits in the next cycle

endmodule

// ==== rtl/icache_refill.sv ====
`timescale 1ns/1ps

module icache_refill #(
	parameter int sets  = icache_pkg::def_sets,
	parameter int words = icache_pkg::def_words,
	localparam int idx_w = $clog2(sets),
	localparam int off_w = $clog2(words),
	localparam int tag_w = icache_pkg::addr_w - idx_w - off_w - 2
)(
	input  logic                                clk,
	input  logic                                rst,
	input  logic                                miss,         // lookup found no way
	input  logic [tag_w-1:0]                    lookup_tag,
	input  logic [idx_w-1:0]                    lookup_index,
	output logic                                mem_req,      // address request
	output logic [icache_pkg::addr_w-1:0]       mem_read_addr,
	input  logic                                mem_addr_ok,  // address taken
	input  logic [icache_pkg::word_w-1:0]       mem_read_data,
	input  logic                                mem_data_ok,  // one word back
	output logic [words*icache_pkg::word_w-1:0] fill_line,    // assembled line
	output logic                                fill_we       // one cycle write strobe
);
	import icache_pkg::*;

	// counters need one more bit to reach words
	localparam int cnt_w = off_w + 1;

	refill_state_t state_q;

	logic [cnt_w-1:0]       addr_cnt_q;  // addresses accepted so far
	logic [cnt_w-1:0]       data_cnt_q;  // words returned so far
	logic [tag_w+idx_w-1:0] line_addr_q; // tag and index of the line being filled
	logic [words*word_w-1:0] line_q;     // words collect here

	logic addr_done;  // every address of the line was accepted
	logic addr_take;  // address transfer this cycle
	logic data_take;  // word transfer this cycle
	logic last_data;  // final word of the line arrives

	assign addr_done = (addr_cnt_q == cnt_w'(words));
	assign addr_take = mem_req && mem_addr_ok;
	assign data_take = (state_q == fill) && mem_data_ok;
	assign last_data = data_take && (data_cnt_q == cnt_w'(words - 1));

	// request stays up under back-pressure, address only moves on acceptance
	assign mem_req       = (state_q == fill) && !addr_done;
	assign mem_read_addr = {line_addr_q, addr_cnt_q[off_w-1:0], 2'b00}; // word aligned

	// line goes out straight from the collect register
	assign fill_line = line_q;
	assign fill_we   = (state_q == write);

	// control path
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state_q    <= idle;
			addr_cnt_q <= '0;
			data_cnt_q <= '0;
		end
		else
		begin
			case (state_q)
				idle:
				begin
					if (miss)
					begin
						state_q    <= fill;
						addr_cnt_q <= '0; // start at offset 0
						data_cnt_q <= '0;
					end
				end
				fill:
				begin
					if (addr_take)
						addr_cnt_q <= addr_cnt_q + 1'b1;
					if (data_take)
						data_cnt_q <= data_cnt_q + 1'b1;
					// data never runs ahead of the addresses, so the last
					// word also means every address was already taken
					if (last_data)
						state_q <= write;
				end
				write:
					state_q <= idle; // one cycle strobe, then wait for the next miss
				default:
					state_q <= idle;
			endcase
		end
	end

	// line address is caught when the miss is taken,
	// the top level keeps the cpu address steady anyway
	always_ff @(posedge clk)
	begin
		if ((state_q == idle) && miss)
			line_addr_q <= {lookup_tag, lookup_index};
	end

	// returned words go into the slot the data counter points at
	always_ff @(posedge clk)
	begin
		if (data_take)
			line_q[data_cnt_q[off_w-1:0]*word_w +: word_w] <= mem_read_data;
	end

	// a miss seen in fill or write is the one being served,
	// so it is only looked at in idle
	// the lookup hits the cycle after fill_we and miss drops there

endmodule

// ==== rtl/icache_replace.sv ====
`timescale 1ns/1ps

module icache_replace #(
	parameter int ways = icache_pkg::def_ways,
	parameter int sets = icache_pkg::def_sets,
	localparam int way_w = $clog2(ways),
	localparam int idx_w = $clog2(sets)
)(
	input  logic             clk,
	input  logic             rst,
	input  logic [idx_w-1:0] index,     // addressed set
	input  logic             fill_we,   // line fill into this set
	output logic [way_w-1:0] victim_way // way to replace on the next fill
);

	logic [way_w-1:0] ptr_q [sets]; // round robin pointer per set
	logic [way_w-1:0] ptr_next;

	// next pointer for the addressed set, wraps at ways
	always_comb
	begin
		if (ptr_q[index] == way_w'(ways - 1))
			ptr_next = '0;
		else
			ptr_next = ptr_q[index] + 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int s = 0; s < sets; s++)
				ptr_q[s] <= '0; // every set starts at way 0
		end
		else if (fill_we)
			ptr_q[index] <= ptr_next; // step only the filled set
	end

	// the pointer names the way that gets the line,
	// it moves on in the same edge the line is written
	assign victim_way = ptr_q[index];

endmodule

// ==== rtl/icache_way_ram.sv ====
`timescale 1ns/1ps

module icache_way_ram #(
	parameter int sets  = icache_pkg::def_sets,
	parameter int words = icache_pkg::def_words,
	localparam int idx_w = $clog2(sets),
	localparam int off_w = $clog2(words),
	localparam int tag_w = icache_pkg::addr_w - idx_w - off_w - 2
)(
	input  logic                                clk,
	input  logic                                rst,
	input  logic [idx_w-1:0]                    index, // set select, read and write
	input  logic                                we,    // line write from the refill
	input  logic [tag_w-1:0]                    wtag,
	input  logic [words*icache_pkg::word_w-1:0] wline,
	output logic                                valid,
	output logic [tag_w-1:0]                    tag,
	output logic [words*icache_pkg::word_w-1:0] line
);
	import icache_pkg::*;

	logic [sets-1:0]         valid_q;          // one valid bit per set
	logic [tag_w-1:0]        tag_q  [sets];    // tag array
	logic [words*word_w-1:0] data_q [sets];    // whole lines, word 0 low

	// valid bits are control state and start clear
	always_ff @(posedge clk)
	begin
		if (rst)
			valid_q <= '0;
		else if (we)
			valid_q[index] <= 1'b1; // a filled set stays valid, no invalidation
	end

	// tag and data arrays, plain storage
	always_ff @(posedge clk)
	begin
		if (we)
		begin
			tag_q[index]  <= wtag;
			data_q[index] <= wline;
		end
	end

	// asynchronous read, hit logic sits right behind these
	assign valid = valid_q[index];
	assign tag   = tag_q[index];
	assign line  = data_q[index];

	// a write lands at the edge where we is high,
	// the following cycle already reads the new line

endmodule

// ==== rtl/icache_pkg.sv ====
package icache_pkg;

	// fetch port and memory port widths
	localparam int addr_w = 32; // byte address, cpu and memory side
	localparam int word_w = 32; // one instruction word

	// default geometry, the top level may override these
	localparam int def_ways  = 2;  // associativity
	localparam int def_sets  = 16; // sets per way
	localparam int def_words = 4;  // words in one line

	// the byte offset inside a word is always two bits
	// tag, index and offset widths follow from sets and words in each module

	// refill controller states
	// idle  - waiting for a miss from the lookup
	// fill  - requesting addresses and collecting returned words
	// write - line complete, one cycle write strobe into the victim way
	typedef enum logic [1:0]
	{
		idle  = 2'd0,
		fill  = 2'd1,
		write = 2'd2
	} refill_state_t;

	// notes on the memory port
	// addresses and returned words are counted apart,
	// so up to one line worth of requests can be in flight
	// data always comes back in request order

	// a line is packed with word 0 in the low bits,
	// word n at bits [n*word_w +: word_w]

endpackage
